// File: src/cache_pkg.sv
package cache_pkg;

    // geometry
    localparam int addr_w     = 32;
    localparam int line_bytes = 16;
    localparam int line_w     = line_bytes * 8;
    localparam int sets       = 64;
    localparam int ways       = 4;
    localparam int way_w      = 2;
    localparam int offset_w   = 4;
    localparam int index_w    = 6;
    localparam int tag_w      = addr_w - index_w - offset_w;
    localparam int plru_w     = ways - 1; // root, low-half node, high-half node

    // access size codes shared with the cpu side
    localparam logic [1:0] size_word = 2'd0;
    localparam logic [1:0] size_byte = 2'd1;
    localparam logic [1:0] size_half = 2'd2;

    // controller states
    localparam logic [2:0] st_idle       = 3'd0;
    localparam logic [2:0] st_lookup     = 3'd1;
    localparam logic [2:0] st_write_back = 3'd2;
    localparam logic [2:0] st_fill       = 3'd3;
    localparam logic [2:0] st_relookup   = 3'd4;

    // one address seen as a flat word or split into cache fields
    typedef union packed {
        logic [addr_w-1:0] raw;
        struct packed {
            logic [tag_w-1:0]    tag;
            logic [index_w-1:0]  index;
            logic [offset_w-1:0] offset;
        } fld;
    } cache_addr_t;

endpackage

// File: src/cache_way.sv
`timescale 1ns/1ps

module cache_way (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           sel,
    input  logic [cache_pkg::index_w-1:0]  index,
    input  logic [cache_pkg::offset_w-1:0] offset,
    input  logic [21:0]                    tag_in,
    input  logic [1:0]                     size,
    input  logic                           store,
    input  logic                           load,
    input  logic [31:0]                    wdata,
    input  logic [127:0]                   fill_data,
    output logic                           way_hit,
    output logic                           way_valid,
    output logic                           way_dirty,
    output logic [21:0]                    way_tag,
    output logic [127:0]                   line_out,
    output logic [31:0]                    word_out
);

    logic [cache_pkg::line_w-1:0] data_mem [cache_pkg::sets];
    logic [cache_pkg::tag_w-1:0]  tag_mem  [cache_pkg::sets];
    logic [cache_pkg::sets-1:0]   valid_bits;
    logic [cache_pkg::sets-1:0]   dirty_bits;

    logic [6:0] lane_bit; // bit position of the addressed byte

    assign lane_bit = {offset, 3'b000};

    assign way_valid = valid_bits[index];
    assign way_dirty = dirty_bits[index];
    assign way_tag   = tag_mem[index];
    assign way_hit   = way_valid && (way_tag == tag_in);
    assign line_out  = data_mem[index];
    assign word_out  = line_out[{offset[3:2], 5'b00000} +: 32]; // aligned word holding offset

    // line data and tag where load wins over store
    always_ff @(posedge clk) begin
        if (sel && load) begin
            data_mem[index] <= fill_data;
            tag_mem[index]  <= tag_in;
        end else if (sel && store) begin
            case (size)
                cache_pkg::size_byte: data_mem[index][lane_bit +: 8]  <= wdata[7:0];
                cache_pkg::size_half: data_mem[index][lane_bit +: 16] <= wdata[15:0];
                default:              data_mem[index][lane_bit +: 32] <= wdata;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (sel && load) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= 1'b0; // fresh copy of memory
        end else if (sel && store) begin
            dirty_bits[index] <= 1'b1;
        end
    end

    // naturally aligned stores only
    a_store_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        store |-> !((size == cache_pkg::size_half && offset[0]) ||
                    (size == cache_pkg::size_word && offset[1:0] != 2'b00))
    ) else $error("misaligned store, size %0d offset %0d", size, offset);

    // controller never refills and writes in the same cycle
    a_load_store_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load && store)
    ) else $error("load and store together");

endmodule

// File: src/way_select.sv
`timescale 1ns/1ps

module way_select (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [cache_pkg::index_w-1:0] index,
    input  logic [3:0]                    way_hit,
    input  logic [3:0]                    way_valid,
    input  logic                          lookup,
    input  logic                          touch,
    input  logic                          load,
    output logic [3:0]                    sel,
    output logic [1:0]                    victim
);

    // bit 0 of each set is the root, bit 1 the node for ways 0/1, bit 2 the node for ways 2/3
    logic [cache_pkg::plru_w-1:0] plru [cache_pkg::sets];

    logic [cache_pkg::plru_w-1:0] cur;
    logic [cache_pkg::way_w-1:0]  used_way;
    logic [cache_pkg::ways-1:0]   victim_oh;

    assign cur = plru[index];

    always_comb begin
        used_way = '0;
        for (int i = 0; i < cache_pkg::ways; i++) begin
            if (way_hit[i])
                used_way = cache_pkg::way_w'(i);
        end
    end

    // empty ways first, else walk the tree away from recent use
    always_comb begin
        victim[1] = ~cur[0];
        victim[0] = cur[0] ? ~cur[1] : ~cur[2];
        for (int i = cache_pkg::ways - 1; i >= 0; i--) begin
            if (!way_valid[i])
                victim = cache_pkg::way_w'(i); // lowest invalid wins
        end
    end

    assign victim_oh = cache_pkg::ways'(1) << victim;

    always_comb begin
        if (load)
            sel = victim_oh;
        else if (lookup)
            sel = way_hit;
        else
            sel = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < cache_pkg::sets; s++)
                plru[s] <= '0;
        end else if (touch) begin
            plru[index][0] <= used_way[1];
            if (used_way[1])
                plru[index][2] <= used_way[0];
            else
                plru[index][1] <= used_way[0];
        end
    end

    // tags within one set stay unique across the ways
    a_single_hit: assert property (
        @(posedge clk) disable iff (!rst_n)
        lookup |-> $onehot0(way_hit)
    ) else $error("multiple ways hit in set %0d", index);

endmodule

// File: src/way_merge.sv
`timescale 1ns/1ps

module way_merge (
    input  logic [3:0]                     way_hit,
    input  logic [3:0]                     way_dirty,
    input  logic [87:0]                    way_tags,
    input  logic [511:0]                   line_outs,
    input  logic [127:0]                   word_outs,
    input  logic [1:0]                     victim,
    input  logic [cache_pkg::offset_w-1:0] offset,
    input  logic [1:0]                     size,
    output logic                           any_hit,
    output logic [1:0]                     hit_way,
    output logic                           victim_dirty,
    output logic [21:0]                    victim_tag,
    output logic [127:0]                   victim_line,
    output logic [31:0]                    rdata
);

    logic [31:0] hit_word;

    assign any_hit = |way_hit;

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < cache_pkg::ways; i++) begin
            if (way_hit[i])
                hit_way = cache_pkg::way_w'(i);
        end
    end

    assign hit_word = word_outs[{hit_way, 5'b00000} +: 32];

    // zero-extended lane pick
    always_comb begin
        case (size)
            cache_pkg::size_byte: rdata = {24'd0, hit_word[{offset[1:0], 3'b000} +: 8]};
            cache_pkg::size_half: rdata = {16'd0, hit_word[{offset[1], 4'b0000} +: 16]};
            default:              rdata = hit_word;
        endcase
    end

    // victim side for write-back
    assign victim_dirty = way_dirty[victim];
    assign victim_tag   = way_tags[victim * cache_pkg::tag_w +: cache_pkg::tag_w];
    assign victim_line  = line_outs[victim * cache_pkg::line_w +: cache_pkg::line_w];

endmodule

// File: src/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    input  logic                  write,
    input  logic [31:0]           addr,
    input  logic [31:0]           wdata,
    input  logic [1:0]            size,
    output logic                  busy,
    output logic                  done,
    output logic                  hit,
    output logic [31:0]           rdata,
    input  logic                  any_hit,
    input  logic                  victim_dirty,
    input  logic [21:0]           victim_tag,
    input  logic [127:0]          victim_line,
    input  logic [31:0]           merged_rdata,
    output cache_pkg::cache_addr_t req_addr,
    output logic [31:0]           req_wdata,
    output logic [1:0]            req_size,
    output logic                  lookup,
    output logic                  store,
    output logic                  touch,
    output logic                  load,
    output logic [127:0]          fill_data,
    output logic                  wb_req,
    output logic [31:0]           wb_addr,
    output logic [127:0]          wb_data,
    input  logic                  wb_ack,
    output logic                  fill_req,
    output logic [31:0]           fill_addr,
    input  logic                  fill_valid,
    input  logic [127:0]          fill_in
);

    logic [2:0] state;
    logic       req_write;
    logic       missed;       // first lookup missed
    logic       mem_pending;  // a memory request is in flight

    cache_pkg::cache_addr_t wb_line;
    cache_pkg::cache_addr_t fill_line;

    always_comb begin
        wb_line            = req_addr;
        wb_line.fld.tag    = victim_tag;
        wb_line.fld.offset = '0;
        fill_line            = req_addr;
        fill_line.fld.offset = '0;
    end

    assign busy   = (state != cache_pkg::st_idle);
    assign lookup = (state == cache_pkg::st_lookup) || (state == cache_pkg::st_relookup);
    assign done   = (state == cache_pkg::st_lookup && any_hit) ||
                    (state == cache_pkg::st_relookup);
    assign hit    = done && !missed;
    assign touch  = done;
    assign store  = done && req_write;
    assign load   = (state == cache_pkg::st_fill) && fill_valid;
    assign rdata  = (done && !req_write) ? merged_rdata : '0;

    assign fill_data = fill_in; // refill line straight into the victim way
    assign fill_addr = fill_line.raw;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= cache_pkg::st_idle;
            req_addr  <= '0;
            req_wdata <= '0;
            req_size  <= '0;
            req_write <= 1'b0;
            missed    <= 1'b0;
            wb_req    <= 1'b0;
            wb_addr   <= '0;
            wb_data   <= '0;
            fill_req  <= 1'b0;
        end else begin
            wb_req   <= 1'b0;
            fill_req <= 1'b0;
            case (state)
                cache_pkg::st_idle: if (req) begin
                    state     <= cache_pkg::st_lookup;
                    req_addr  <= addr;
                    req_wdata <= wdata;
                    req_size  <= size;
                    req_write <= write;
                    missed    <= 1'b0;
                end
                cache_pkg::st_lookup: begin
                    if (any_hit) begin
                        state <= cache_pkg::st_idle;
                    end else begin
                        missed <= 1'b1;
                        if (victim_dirty) begin
                            state   <= cache_pkg::st_write_back;
                            wb_req  <= 1'b1;
                            wb_addr <= wb_line.raw;
                            wb_data <= victim_line; // snapshot before refill
                        end else begin
                            state    <= cache_pkg::st_fill;
                            fill_req <= 1'b1;
                        end
                    end
                end
                cache_pkg::st_write_back: if (wb_ack) begin
                    state    <= cache_pkg::st_fill;
                    fill_req <= 1'b1;
                end
                cache_pkg::st_fill: if (fill_valid) state <= cache_pkg::st_relookup;
                default: state <= cache_pkg::st_idle; // relookup always completes
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            mem_pending <= 1'b0;
        else if (wb_req || fill_req)
            mem_pending <= 1'b1;
        else if (wb_ack || fill_valid)
            mem_pending <= 1'b0;
    end

    // no completion while memory still owes an answer
    a_no_done_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem_pending || wb_req || fill_req) |-> !done
    ) else $error("done while memory request pending");

endmodule

// File: src/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         req,
    input  logic         write,
    input  logic [31:0]  addr,
    input  logic [31:0]  wdata,
    input  logic [1:0]   size,
    output logic         busy,
    output logic         done,
    output logic         hit,
    output logic [31:0]  rdata,
    output logic         wb_req,
    output logic [31:0]  wb_addr,
    output logic [127:0] wb_data,
    input  logic         wb_ack,
    output logic         fill_req,
    output logic [31:0]  fill_addr,
    input  logic         fill_valid,
    input  logic [127:0] fill_data
);

    cache_pkg::cache_addr_t req_addr;

    logic [31:0]  req_wdata;
    logic [1:0]   req_size;
    logic         lookup;
    logic         store;
    logic         touch;
    logic         load;
    logic [127:0] line_fill;

    logic [3:0]   sel;
    logic [1:0]   victim;
    logic [3:0]   way_hit;
    logic [3:0]   way_valid;
    logic [3:0]   way_dirty;
    logic [87:0]  way_tags;   // way i at [i*22 +: 22]
    logic [511:0] line_outs;
    logic [127:0] word_outs;

    logic         any_hit;
    logic         victim_dirty;
    logic [21:0]  victim_tag;
    logic [127:0] victim_line;
    logic [31:0]  merged_rdata;

    cache_ctrl cache_ctrl_inst (
        .clk(clk), .rst_n(rst_n),
        .req(req), .write(write), .addr(addr), .wdata(wdata), .size(size),
        .busy(busy), .done(done), .hit(hit), .rdata(rdata),
        .any_hit(any_hit), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag), .victim_line(victim_line),
        .merged_rdata(merged_rdata),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_size(req_size),
        .lookup(lookup), .store(store), .touch(touch), .load(load),
        .fill_data(line_fill),
        .wb_req(wb_req), .wb_addr(wb_addr), .wb_data(wb_data), .wb_ack(wb_ack),
        .fill_req(fill_req), .fill_addr(fill_addr), .fill_valid(fill_valid),
        .fill_in(fill_data)
    );

    way_select way_select_inst (
        .clk(clk), .rst_n(rst_n), .index(req_addr.fld.index),
        .way_hit(way_hit), .way_valid(way_valid),
        .lookup(lookup), .touch(touch), .load(load),
        .sel(sel), .victim(victim)
    );

    for (genvar i = 0; i < cache_pkg::ways; i++) begin : way_gen
        cache_way cache_way_inst (
            .clk(clk), .rst_n(rst_n), .sel(sel[i]),
            .index(req_addr.fld.index), .offset(req_addr.fld.offset),
            .tag_in(req_addr.fld.tag), .size(req_size),
            .store(store), .load(load), .wdata(req_wdata), .fill_data(line_fill),
            .way_hit(way_hit[i]), .way_valid(way_valid[i]), .way_dirty(way_dirty[i]),
            .way_tag(way_tags[i*cache_pkg::tag_w +: cache_pkg::tag_w]),
            .line_out(line_outs[i*cache_pkg::line_w +: cache_pkg::line_w]),
            .word_out(word_outs[i*cache_pkg::addr_w +: cache_pkg::addr_w])
        );
    end

    way_merge way_merge_inst (
        .way_hit(way_hit), .way_dirty(way_dirty), .way_tags(way_tags),
        .line_outs(line_outs), .word_outs(word_outs), .victim(victim),
        .offset(req_addr.fld.offset), .size(req_size),
        .any_hit(any_hit), .hit_way(),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .victim_line(victim_line), .rdata(merged_rdata)
    );

endmodule

// File: tb/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

    localparam int cycles_per_vector = 200;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         req;
    logic         write;
    logic [31:0]  addr;
    logic [31:0]  wdata;
    logic [1:0]   size;
    logic         busy;
    logic         done;
    logic         hit;
    logic [31:0]  rdata;
    logic         wb_req;
    logic [31:0]  wb_addr;
    logic [127:0] wb_data;
    logic         wb_ack;
    logic         fill_req;
    logic [31:0]  fill_addr;
    logic         fill_valid;
    logic [127:0] fill_data;

    logic [31:0] mem [logic [31:0]]; // only words that came back from the cache
    logic [31:0] vec_op [$];
    logic [31:0] vec_size [$];
    logic [31:0] vec_addr [$];
    logic [31:0] vec_wdata [$];
    logic [31:0] vec_rdata [$];
    logic [31:0] vec_hit [$];
    int          vec_count = 0;
    integer      seed = 32'h5f37_d3e9;

    cache_top cache_top_inst (
        .clk(clk), .rst_n(rst_n),
        .req(req), .write(write), .addr(addr), .wdata(wdata), .size(size),
        .busy(busy), .done(done), .hit(hit), .rdata(rdata),
        .wb_req(wb_req), .wb_addr(wb_addr), .wb_data(wb_data), .wb_ack(wb_ack),
        .fill_req(fill_req), .fill_addr(fill_addr), .fill_valid(fill_valid),
        .fill_data(fill_data)
    );

    always #20 clk = ~clk;

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        if (got !== expected) begin
            $display("error: time %0t %s got %h expected %h", $time, name, got, expected);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        if (mem.exists(a))
            return mem[a];
        return a ^ 32'ha5a5_0000; // untouched memory
    endfunction

    function automatic logic [127:0] read_line(input logic [31:0] base);
        logic [127:0] line;
        for (int k = 0; k < 4; k++)
            line[k*32 +: 32] = mem_word(base + 32'(4 * k)); // little-endian words
        return line;
    endfunction

    task automatic write_line(input logic [31:0] base, input logic [127:0] line);
        for (int k = 0; k < 4; k++)
            mem[base + 32'(4 * k)] = line[k*32 +: 32];
    endtask

    task automatic load_vectors();
        int          fd;
        int          code;
        string       line;
        logic [31:0] op, sz, a, wd, er, eh;
        fd = $fopen("tb/cache_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file tb/cache_vectors.txt");
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line.getc(0) == "#")
                continue; // blank or column notes
            if ($sscanf(line, "%h %h %h %h %h %h", op, sz, a, wd, er, eh) != 6) begin
                $display("malformed line in the vector file: %s", line);
                $display("*** TEST FAILED ***");
                $fatal(1);
            end
            vec_op.push_back(op);
            vec_size.push_back(sz);
            vec_addr.push_back(a);
            vec_wdata.push_back(wd);
            vec_rdata.push_back(er);
            vec_hit.push_back(eh);
        end
        $fclose(fd);
        vec_count = vec_addr.size();
    endtask

    // one cpu access and its wait for done
    task automatic run_access(input int i);
        @(negedge clk);
        check("busy", {31'd0, busy}, 32'd0); // idle between accesses
        check("done", {31'd0, done}, 32'd0);
        req   = 1'b1;
        write = vec_op[i][0];
        addr  = vec_addr[i];
        wdata = vec_wdata[i];
        size  = vec_size[i][1:0];
        @(negedge clk);
        req = 1'b0;
        check("busy", {31'd0, busy}, 32'd1);
        while (!done) begin
            @(negedge clk);
            check("busy", {31'd0, busy}, 32'd1);
        end
        check("rdata", rdata, vec_rdata[i]);
        check("hit", {31'd0, hit}, vec_hit[i]);
    endtask

    initial begin
        rst_n = 1'b0;
        req   = 1'b0;
        write = 1'b0;
        addr  = '0;
        wdata = '0;
        size  = '0;
        load_vectors();
        if (vec_count == 0) begin
            $display("the vector file holds no vectors");
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < vec_count; i++)
            run_access(i);
        @(negedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

    // memory with random latency of 1 to 8 cycles
    initial begin : memory_model
        int          wb_cnt;
        int          fill_cnt;
        logic [31:0] fill_base;
        wb_ack     = 1'b0;
        fill_valid = 1'b0;
        fill_data  = '0;
        wb_cnt     = 0;
        fill_cnt   = 0;
        fill_base  = '0;
        forever begin
            @(negedge clk);
            wb_ack     = 1'b0;
            fill_valid = 1'b0;
            if (wb_cnt > 0) begin
                wb_cnt = wb_cnt - 1;
                if (wb_cnt == 0)
                    wb_ack = 1'b1;
            end
            if (fill_cnt > 0) begin
                fill_cnt = fill_cnt - 1;
                if (fill_cnt == 0) begin
                    fill_data  = read_line(fill_base);
                    fill_valid = 1'b1;
                end
            end
            if (wb_req) begin
                check("wb_addr offset", {28'd0, wb_addr[3:0]}, 32'd0);
                write_line(wb_addr, wb_data);
                wb_cnt = 1 + ($unsigned($random(seed)) % 8);
            end
            if (fill_req) begin
                check("fill_addr offset", {28'd0, fill_addr[3:0]}, 32'd0);
                fill_base = fill_addr;
                fill_cnt  = 1 + ($unsigned($random(seed)) % 8);
            end
        end
    end

    initial begin
        wait (vec_count > 0);
        repeat (10 + vec_count * cycles_per_vector) @(posedge clk);
        $display("timeout: the accesses did not complete in %0d cycles",
                 vec_count * cycles_per_vector);
        $display("*** TEST FAILED ***");
        $fatal(1);
    end

endmodule

// File: tb/cache_vectors.txt
# op size addr wdata rdata hit, all hex
# op 0 load 1 store, size 0 word 1 byte 2 half, rdata and hit are the expected results
0 0 00001000 00000000 a5a51000 0
0 0 00001004 00000000 a5a51004 1
0 1 00001008 00000000 00000008 1
0 1 00001009 00000000 00000010 1
0 1 0000100a 00000000 000000a5 1
0 2 0000100e 00000000 0000a5a5 1
1 1 00001001 000000ee 00000000 1
1 2 00001002 00001234 00000000 1
0 0 00001000 00000000 1234ee00 1
0 0 00001400 00000000 a5a51400 0
1 0 00001800 deadbeef 00000000 0
0 0 00001c00 00000000 a5a51c00 0
0 0 00002000 00000000 a5a52000 0
0 0 00001404 00000000 a5a51404 1
0 0 00001000 00000000 1234ee00 0
0 0 00001800 00000000 deadbeef 0
0 2 00001c0a 00000000 0000a5a5 1
0 0 00002000 00000000 a5a52000 0

// File: files.f
src/cache_pkg.sv
src/cache_way.sv
src/way_select.sv
src/way_merge.sv
src/cache_ctrl.sv
src/cache_top.sv
tb/cache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module cache_tb \
    -Mdir obj_dir -o cache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/cache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0
